/* verilog/testMonPkg.sv */
// widths, limits, register map and record types shared by the test-status monitor blocks
package testMonPkg;

   // ----------------------------------------------------------------------
   // widths and limits
   // ----------------------------------------------------------------------
   localparam int PC_MATCH_BITS = 30;          // low pc bits compared
   typedef logic [PC_MATCH_BITS-1:0] pcT;

   localparam int WB_DATA_BITS = 32;
   typedef logic [WB_DATA_BITS-1:0] wbDataT;

   localparam int WB_ADR_BITS = 4;             // word address
   typedef logic [WB_ADR_BITS-1:0] wbAdrT;

   localparam int ADR_SLOTS = 5;

   // repeats of one pc before the core counts as stuck
   localparam int STUCK_LIMIT = 500;
   typedef logic [$clog2(STUCK_LIMIT+1)-1:0] stuckCntT;

   localparam int SLEEP_DELAY = 20;            // verdict to core hold
   typedef logic [$clog2(SLEEP_DELAY)-1:0] sleepCntT;

   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
   typedef logic [FIFO_PTR_BITS-1:0] fifoPtrT;
   typedef logic [FIFO_PTR_BITS:0] fifoCntT;   // holds 0 to FIFO_DEPTH

   // ----------------------------------------------------------------------
   // register map, word addresses
   // ----------------------------------------------------------------------
   localparam wbAdrT REG_CTRL     = 4'd0;
   localparam wbAdrT REG_STATUS   = 4'd1;
   localparam wbAdrT REG_VERDICT  = 4'd2;
   localparam wbAdrT REG_ADR_BASE = 4'd4;      // table slots 4 to 8

   // table slot roles
   localparam int SLOT_PASS   = 0;
   localparam int SLOT_FAIL   = 1;
   localparam int SLOT_FINISH = 2;             // counts as a pass
   localparam int SLOT_TOHOST = 3;             // pass, only with checkToHost
   localparam int SLOT_FAIL2  = 4;

   // ----------------------------------------------------------------------
   // types
   // ----------------------------------------------------------------------
   typedef enum logic [1:0] {
      verdictNone,
      verdictPass,
      verdictFail,
      verdictStuck
   } verdictE;

   // kind lands in bits 31:30 of a verdict read
   typedef struct packed {
      verdictE kind;
      pcT      pc;
   } verdictRecT;

   typedef struct packed {
      logic valid;
      pcT   pc;
   } traceT;

   typedef pcT [ADR_SLOTS-1:0] adrTableT;

   typedef struct packed {
      logic   cyc;
      logic   stb;
      logic   we;
      wbAdrT  adr;
      wbDataT dat;
   } wbReqT;

   typedef struct packed {
      logic   ack;
      wbDataT dat;
   } wbRspT;

   typedef struct packed {
      logic passSeen;
      logic failSeen;
      logic coreHold;
      logic overflow;
   } monStatusT;

endpackage

/* verilog/traceMatcher.sv */
// watches the pc trace, matches it to the address table, flags stuck loops and holds the core
`timescale 1ns/1ns
module traceMatcher (
   input  logic                    dvtFlags,
   input  logic                    pcFail,
   input  testMonPkg::traceT       trace,
   input  testMonPkg::adrTableT    adrTable,
   input  logic                    checkToHost,
   input  logic                    timeoutFail,
   output logic                    pushValid,
   output testMonPkg::verdictRecT  pushRec,
   input  logic                    pushReady,
   output testMonPkg::monStatusT   status
);
   import testMonPkg::*;

   logic beatValid;
   logic [ADR_SLOTS-1:0] slotHit;
   logic passHit, failHit, stuckHit;
   logic failBeat, verdictHit, canTake;
   logic samePc;
   pcT lastPc;
   stuckCntT stuckCnt, nextCnt;
   verdictE newKind;
   logic passSeen, failSeen, coreHold, overflow;
   logic armed;
   sleepCntT sleepCnt;

   // ----------------------------------------------------------------------
   // match
   // ----------------------------------------------------------------------
   assign beatValid = trace.valid && !coreHold;   // core asleep, trace ignored

   always_comb begin
      for (int i = 0; i < ADR_SLOTS; i++) begin
         slotHit[i] = (trace.pc == adrTable[i]);
      end
   end

   // slots 2 to 4 only count once programmed
   assign passHit = beatValid &&
                    (slotHit[SLOT_PASS] ||
                     (slotHit[SLOT_FINISH] && adrTable[SLOT_FINISH] != '0) ||
                     (slotHit[SLOT_TOHOST] && adrTable[SLOT_TOHOST] != '0 && checkToHost));
   assign failHit = beatValid &&
                    (slotHit[SLOT_FAIL] ||
                     (slotHit[SLOT_FAIL2] && adrTable[SLOT_FAIL2] != '0));

   // ----------------------------------------------------------------------
   // stuck loop
   // ----------------------------------------------------------------------
   // stuckCnt is the length of the current run of one pc
   assign samePc = (trace.pc == lastPc);

   always_comb begin
      if (!samePc) begin
         nextCnt = stuckCntT'(1);
      end else if (stuckCnt == stuckCntT'(STUCK_LIMIT)) begin
         nextCnt = stuckCnt;                       // saturate, fire once
      end else begin
         nextCnt = stuckCnt + 1'b1;
      end
   end

   assign stuckHit = beatValid && samePc && (stuckCnt == stuckCntT'(STUCK_LIMIT - 1));

   assign failBeat   = failHit || stuckHit;
   assign verdictHit = passHit || failBeat;
   assign newKind    = stuckHit ? verdictStuck : (failHit ? verdictFail : verdictPass);

   // pending slot is free when empty or draining this edge
   assign canTake = !pushValid || pushReady;

   // ----------------------------------------------------------------------
   // status, pending record, sleep countdown
   // ----------------------------------------------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         lastPc    <= '0;
         stuckCnt  <= '0;
         passSeen  <= 1'b0;
         failSeen  <= 1'b0;
         overflow  <= 1'b0;
         pushValid <= 1'b0;
         armed     <= 1'b0;
         sleepCnt  <= '0;
         coreHold  <= 1'b0;
      end else begin
         if (beatValid) begin
            lastPc   <= trace.pc;
            stuckCnt <= nextCnt;
         end
         if (passHit && !failBeat) passSeen <= 1'b1;   // fail wins
         if (failBeat || timeoutFail) failSeen <= 1'b1;

         if (canTake) begin
            pushValid <= verdictHit;
         end else if (verdictHit) begin
            overflow <= 1'b1;                          // dropped, sticky
         end

         if (verdictHit && !armed) begin
            armed    <= 1'b1;
            sleepCnt <= sleepCntT'(SLEEP_DELAY - 1);
         end else if (armed && !coreHold) begin
            if (sleepCnt == '0) coreHold <= 1'b1;
            else sleepCnt <= sleepCnt - 1'b1;
         end
      end
   end

   always_ff @(posedge dvtFlags) begin
      if (canTake && verdictHit) begin
         pushRec.kind <= newKind;
         pushRec.pc   <= trace.pc;
      end
   end

   assign status.passSeen = passSeen;
   assign status.failSeen = failSeen;
   assign status.coreHold = coreHold;
   assign status.overflow = overflow;

   // a stalled record stays put until the FIFO takes it
   apPendingStable : assert property (@(posedge dvtFlags) disable iff (pcFail)
      pushValid && !pushReady |=> pushValid && $stable(pushRec));

endmodule

/* verilog/verdictFifo.sv */
// small circular FIFO of verdict records between the trace matcher and the host registers
`timescale 1ns/1ns
module verdictFifo (
   input  logic                    dvtFlags,
   input  logic                    pcFail,
   input  logic                    pushValid,
   input  testMonPkg::verdictRecT  pushRec,
   output logic                    pushReady,
   input  logic                    pop,
   output logic                    popValid,
   output testMonPkg::verdictRecT  popRec
);
   import testMonPkg::*;

   verdictRecT mem [FIFO_DEPTH];
   fifoPtrT wrPtr, rdPtr;
   fifoCntT count;
   logic doPush, doPop;

   assign pushReady = (count != fifoCntT'(FIFO_DEPTH));
   assign popValid  = (count != '0);
   assign popRec    = mem[rdPtr];                  // head shown directly

   assign doPush = pushValid && pushReady;
   assign doPop  = pop && popValid;

   // ----------------------------------------------------------------------
   // pointers and fill level
   // ----------------------------------------------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) begin
            wrPtr <= (wrPtr == fifoPtrT'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         end
         if (doPop) begin
            rdPtr <= (rdPtr == fifoPtrT'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         end
         case ({doPush, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;               // none, or both at once
         endcase
      end
   end

   // record storage
   always_ff @(posedge dvtFlags) begin
      if (doPush) mem[wrPtr] <= pushRec;
   end

   // the register block only pops what it saw as present
   apNoEmptyPop : assert property (@(posedge dvtFlags) disable iff (pcFail)
      pop |-> popValid);

endmodule

/* verilog/statusRegs.sv */
// Wishbone classic slave holding control, status, verdict pop and the address table
`timescale 1ns/1ns
module statusRegs (
   input  logic                    dvtFlags,
   input  logic                    pcFail,
   input  testMonPkg::wbReqT       wbReq,
   output testMonPkg::wbRspT       wbRsp,
   output testMonPkg::adrTableT    adrTable,
   output logic                    checkToHost,
   output logic                    timeoutFail,
   input  testMonPkg::monStatusT   status,
   input  logic                    popValid,
   input  testMonPkg::verdictRecT  popRec,
   output logic                    pop
);
   import testMonPkg::*;

   localparam verdictRecT EMPTY_REC = '{kind: verdictNone, pc: '0};

   logic ack;
   logic reqFire, reqRead, reqWrite;
   wbDataT rdMux, rdData;

   // ----------------------------------------------------------------------
   // request decode
   // ----------------------------------------------------------------------
   // one ack per sampled request, never back to back
   assign reqFire  = wbReq.cyc && wbReq.stb && !ack;
   assign reqRead  = reqFire && !wbReq.we;
   assign reqWrite = reqFire && wbReq.we;

   // ----------------------------------------------------------------------
   // read mux
   // ----------------------------------------------------------------------
   always_comb begin
      rdMux = '0;
      case (wbReq.adr)
         REG_CTRL: begin
            rdMux = wbDataT'(checkToHost);         // bit 1 reads zero
         end
         REG_STATUS: begin
            rdMux = wbDataT'({!popValid, status.overflow, status.coreHold,
                              status.failSeen, status.passSeen});
         end
         REG_VERDICT: begin
            rdMux = popValid ? wbDataT'(popRec) : wbDataT'(EMPTY_REC);
         end
         default: begin
            for (int i = 0; i < ADR_SLOTS; i++) begin
               if (wbReq.adr == wbAdrT'(REG_ADR_BASE + i)) begin
                  rdMux = wbDataT'(adrTable[i]);
               end
            end
         end
      endcase
   end

   // ----------------------------------------------------------------------
   // control registers and strobes
   // ----------------------------------------------------------------------
   always_ff @(posedge dvtFlags or posedge pcFail) begin
      if (pcFail) begin
         ack         <= 1'b0;
         pop         <= 1'b0;
         timeoutFail <= 1'b0;
         checkToHost <= 1'b0;
         adrTable    <= '0;                        // zero slot is disabled
      end else begin
         ack <= reqFire;
         // popped on the ack edge, head already captured
         pop <= reqRead && (wbReq.adr == REG_VERDICT) && popValid;
         timeoutFail <= reqWrite && (wbReq.adr == REG_CTRL) && wbReq.dat[1];

         if (reqWrite && wbReq.adr == REG_CTRL) begin
            checkToHost <= wbReq.dat[0];
         end
         if (reqWrite) begin
            for (int i = 0; i < ADR_SLOTS; i++) begin
               if (wbReq.adr == wbAdrT'(REG_ADR_BASE + i)) begin
                  adrTable[i] <= wbReq.dat[PC_MATCH_BITS-1:0];
               end
            end
         end
      end
   end

   // read data, only meaningful with ack
   always_ff @(posedge dvtFlags) begin
      if (reqRead) rdData <= rdMux;
   end

   assign wbRsp.ack = ack;
   assign wbRsp.dat = rdData;

   // host must see ack drop between transfers
   apAckPulse : assert property (@(posedge dvtFlags) disable iff (pcFail)
      wbRsp.ack |=> !wbRsp.ack);

endmodule

/* verilog/testMonTop.sv */
// top of the test-status monitor; the host reaches it over Wishbone, the core feeds its pc trace
`timescale 1ns/1ns
module testMonTop (
   input  logic                dvtFlags,
   input  logic                pcFail,
   input  testMonPkg::traceT   trace,
   input  testMonPkg::wbReqT   wbReq,
   output testMonPkg::wbRspT   wbRsp,
   output logic                coreHold
);
   import testMonPkg::*;

   // matcher to FIFO
   logic pushValid, pushReady;
   verdictRecT pushRec;

   // FIFO to registers
   logic pop, popValid;
   verdictRecT popRec;

   // registers to matcher and back
   adrTableT adrTable;
   logic checkToHost, timeoutFail;
   monStatusT status;

   traceMatcher traceMatcher_i (
      .dvtFlags    (dvtFlags),
      .pcFail      (pcFail),
      .trace       (trace),
      .adrTable    (adrTable),
      .checkToHost (checkToHost),
      .timeoutFail (timeoutFail),
      .pushValid   (pushValid),
      .pushRec     (pushRec),
      .pushReady   (pushReady),
      .status      (status)
   );

   verdictFifo verdictFifo_i (
      .dvtFlags  (dvtFlags),
      .pcFail    (pcFail),
      .pushValid (pushValid),
      .pushRec   (pushRec),
      .pushReady (pushReady),
      .pop       (pop),
      .popValid  (popValid),
      .popRec    (popRec)
   );

   statusRegs statusRegs_i (
      .dvtFlags    (dvtFlags),
      .pcFail      (pcFail),
      .wbReq       (wbReq),
      .wbRsp       (wbRsp),
      .adrTable    (adrTable),
      .checkToHost (checkToHost),
      .timeoutFail (timeoutFail),
      .status      (status),
      .popValid    (popValid),
      .popRec      (popRec),
      .pop         (pop)
   );

   assign coreHold = status.coreHold;   // core reset request

endmodule

/* test/testMonTb.sv */
// table-driven testbench for the test-status monitor that runs as simulation top over the RTL
`timescale 1ns/1ns
module testMonTb;
   import testMonPkg::*;

   // verdict codes in enum order
   localparam logic [1:0] KIND_NONE  = 2'd0;
   localparam logic [1:0] KIND_PASS  = 2'd1;
   localparam logic [1:0] KIND_FAIL  = 2'd2;
   localparam logic [1:0] KIND_STUCK = 2'd3;
   localparam pcT PASS_PC   = 30'h0000_1000;
   localparam pcT FAIL_PC   = 30'h0000_2000;
   localparam pcT TOHOST_PC = 30'h0000_3000;
   localparam pcT FINISH_PC = 30'h0000_4000;
   localparam pcT FAIL2_PC  = 30'h0000_5000;
   localparam int ROWS = 17;
   localparam int ACK_TIMEOUT  = 20;          // cycles
   localparam int HOLD_TIMEOUT = 100;

   // one trace beat and the verdict it should leave behind
   typedef struct packed {
      logic       filler;                     // pc taken from the LFSR
      pcT         pc;
      logic       valid;
      logic       toHost;
      logic [1:0] kind;
   } rowT;

   logic dvtFlags;
   logic pcFail;
   traceT trace;
   wbReqT wbReq;
   wbRspT wbRsp;
   logic coreHold;

   rowT rows [ROWS];
   wbDataT expQ [$];
   logic [31:0] lfsrState;
   logic curToHost;
   int mismatches;
   int failures;

   testMonTop testMonTop_i (
      .dvtFlags (dvtFlags),
      .pcFail   (pcFail),
      .trace    (trace),
      .wbReq    (wbReq),
      .wbRsp    (wbRsp),
      .coreHold (coreHold)
   );

   always #5 dvtFlags = ~dvtFlags;

   // ----------------------------------------------------------------------
   // stimulus helpers
   // ----------------------------------------------------------------------
   // 32 bit Fibonacci LFSR with taps 32 22 2 1 stepped once per random bit
   function automatic pcT nextFiller();
      logic fb;
      pcT value;
      value = '0;
      for (int i = 0; i < PC_MATCH_BITS - 1; i++) begin
         fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         value = {value[PC_MATCH_BITS-2:0], fb};
      end
      value[PC_MATCH_BITS-1] = 1'b1;          // table addresses all sit below this bit
      return value;
   endfunction

   task automatic applyReset();
      pcFail    = 1'b1;
      trace     = '0;
      wbReq     = '0;
      curToHost = 1'b0;                       // ctrl register clears too
      repeat (16) @(negedge dvtFlags);
      pcFail = 1'b0;
   endtask

   task automatic driveBeat(input logic valid, input pcT pc);
      @(negedge dvtFlags);
      trace.valid = valid;
      trace.pc    = pc;
   endtask

   task automatic idleTrace();
      @(negedge dvtFlags);
      trace.valid = 1'b0;
   endtask

   // one Wishbone classic cycle with the request dropped once ack is seen
   task automatic busTransfer(input logic we, input wbAdrT adr, input wbDataT dat,
                              output wbDataT rdat);
      int waited;
      waited = 0;
      rdat   = '0;
      @(negedge dvtFlags);
      wbReq.cyc = 1'b1;
      wbReq.stb = 1'b1;
      wbReq.we  = we;
      wbReq.adr = adr;
      wbReq.dat = dat;
      @(negedge dvtFlags);
      while (!wbRsp.ack && waited < ACK_TIMEOUT) begin
         @(negedge dvtFlags);
         waited++;
      end
      if (wbRsp.ack) begin
         rdat = wbRsp.dat;
      end else begin
         $display("ERROR at %0t ns: no Wishbone ack for address %0d", $time, adr);
         failures++;
      end
      wbReq = '0;
   endtask

   task automatic writeReg(input wbAdrT adr, input wbDataT dat);
      wbDataT unused;
      busTransfer(1'b1, adr, dat, unused);
   endtask

   task automatic readExpect(input string name, input wbAdrT adr, input wbDataT mask,
                             input wbDataT expected);
      wbDataT rdat;
      busTransfer(1'b0, adr, '0, rdat);
      if ((rdat & mask) !== expected) begin
         $display("MISMATCH at %0t ns: %s expected %h, got %h",
                  $time, name, expected, rdat & mask);
         mismatches++;
      end
   endtask

   // pops every expected record and then reads the empty FIFO once
   task automatic drainVerdicts();
      wbDataT expected;
      while (expQ.size() > 0) begin
         expected = expQ.pop_front();
         readExpect("REG_VERDICT", REG_VERDICT, '1, expected);
      end
      readExpect("REG_VERDICT", REG_VERDICT, '1, '0);
   endtask

   // beats run back to back unless ctrl has to change
   // keep caps the records at the FIFO plus its pending slot
   task automatic applyRows(input int first, input int last, input int keep);
      pcT beatPc;
      for (int r = first; r <= last; r++) begin
         if (rows[r].toHost != curToHost) begin
            idleTrace();
            writeReg(REG_CTRL, wbDataT'(rows[r].toHost));
            curToHost = rows[r].toHost;
         end
         beatPc = rows[r].filler ? nextFiller() : rows[r].pc;
         driveBeat(rows[r].valid, beatPc);
         if (rows[r].kind != KIND_NONE && expQ.size() < keep) begin
            expQ.push_back({rows[r].kind, beatPc});
         end
      end
      idleTrace();
   endtask

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------
   initial begin
      pcT pcA, pcB, pcC;
      int waited;
      dvtFlags   = 1'b0;
      pcFail     = 1'b1;
      trace      = '0;
      wbReq      = '0;
      curToHost  = 1'b0;
      lfsrState  = 32'd69380;
      mismatches = 0;
      failures   = 0;

      // filler, pc, valid, toHost, expected kind
      rows[0]  = {1'b1, 30'h0,     1'b1, 1'b0, KIND_NONE};
      rows[1]  = {1'b0, 30'h0,     1'b1, 1'b0, KIND_NONE};   // zero slot 2
      rows[2]  = {1'b0, TOHOST_PC, 1'b1, 1'b0, KIND_NONE};   // to-host not enabled
      rows[3]  = {1'b0, PASS_PC,   1'b0, 1'b0, KIND_NONE};
      rows[4]  = {1'b0, FAIL_PC,   1'b0, 1'b0, KIND_NONE};
      rows[5]  = {1'b0, PASS_PC,   1'b1, 1'b1, KIND_PASS};
      rows[6]  = {1'b1, 30'h0,     1'b1, 1'b1, KIND_NONE};
      rows[7]  = {1'b0, FAIL_PC,   1'b1, 1'b1, KIND_FAIL};
      rows[8]  = {1'b0, TOHOST_PC, 1'b1, 1'b1, KIND_PASS};
      rows[9]  = {1'b0, PASS_PC,   1'b0, 1'b1, KIND_NONE};
      // overflow burst
      rows[10] = {1'b0, PASS_PC,   1'b1, 1'b0, KIND_PASS};
      rows[11] = {1'b0, FAIL_PC,   1'b1, 1'b0, KIND_FAIL};
      rows[12] = {1'b0, FINISH_PC, 1'b1, 1'b0, KIND_PASS};
      rows[13] = {1'b0, FAIL2_PC,  1'b1, 1'b0, KIND_FAIL};
      rows[14] = {1'b0, PASS_PC,   1'b1, 1'b0, KIND_PASS};
      rows[15] = {1'b0, FAIL_PC,   1'b1, 1'b0, KIND_FAIL};
      rows[16] = {1'b0, FINISH_PC, 1'b1, 1'b0, KIND_PASS};

      applyReset();
      if (wbRsp.ack !== 1'b0) begin
         $display("MISMATCH at %0t ns: wbRsp.ack expected 0, got %b", $time, wbRsp.ack);
         mismatches++;
      end
      if (coreHold !== 1'b0) begin
         $display("MISMATCH at %0t ns: coreHold expected 0, got %b", $time, coreHold);
         mismatches++;
      end
      readExpect("REG_STATUS", REG_STATUS, '1, 32'h10);

      // register readback and timeout strobe
      for (int i = 0; i < ADR_SLOTS; i++) begin
         writeReg(wbAdrT'(REG_ADR_BASE + i), 32'h0ABC_0000 + 32'h111 * i);
      end
      for (int i = 0; i < ADR_SLOTS; i++) begin
         readExpect("adrTable", wbAdrT'(REG_ADR_BASE + i), '1, 32'h0ABC_0000 + 32'h111 * i);
      end
      writeReg(REG_CTRL, 32'h1);
      readExpect("REG_CTRL", REG_CTRL, '1, 32'h1);
      writeReg(REG_CTRL, 32'h3);
      readExpect("REG_CTRL", REG_CTRL, '1, 32'h1);
      readExpect("REG_STATUS", REG_STATUS, '1, 32'h12);   // fail with the FIFO empty
      writeReg(REG_CTRL, 32'h0);
      readExpect("REG_CTRL", REG_CTRL, '1, 32'h0);

      // match rules
      applyReset();
      writeReg(wbAdrT'(REG_ADR_BASE + 0), wbDataT'(PASS_PC));
      writeReg(wbAdrT'(REG_ADR_BASE + 1), wbDataT'(FAIL_PC));
      writeReg(wbAdrT'(REG_ADR_BASE + 3), wbDataT'(TOHOST_PC));
      applyRows(0, 9, FIFO_DEPTH + 1);
      readExpect("REG_STATUS pass/fail", REG_STATUS, 32'h3, 32'h3);
      drainVerdicts();

      // stuck loop with one beat short first
      applyReset();
      pcA = nextFiller();
      pcB = nextFiller();
      pcC = nextFiller();
      repeat (STUCK_LIMIT - 1) driveBeat(1'b1, pcA);
      driveBeat(1'b1, pcB);
      idleTrace();
      readExpect("REG_STATUS", REG_STATUS, '1, 32'h10);
      repeat (STUCK_LIMIT) driveBeat(1'b1, pcC);
      idleTrace();
      readExpect("REG_STATUS fail", REG_STATUS, 32'h2, 32'h2);
      expQ.push_back({KIND_STUCK, pcC});
      drainVerdicts();

      // core hold delay
      applyReset();
      writeReg(wbAdrT'(REG_ADR_BASE + 0), wbDataT'(PASS_PC));
      driveBeat(1'b1, PASS_PC);
      idleTrace();                            // just after the latching edge
      waited = 0;
      while (!coreHold && waited < HOLD_TIMEOUT) begin
         @(negedge dvtFlags);
         waited++;
      end
      if (!coreHold) begin
         $display("ERROR at %0t ns: coreHold never rose after the first verdict", $time);
         failures++;
      end else if (waited != SLEEP_DELAY) begin
         $display("MISMATCH at %0t ns: coreHold delay expected %0d, got %0d",
                  $time, SLEEP_DELAY, waited);
         mismatches++;
      end
      repeat (3) driveBeat(1'b1, PASS_PC);    // ignored while held
      idleTrace();
      readExpect("REG_STATUS", REG_STATUS, '1, 32'h05);
      expQ.push_back({KIND_PASS, PASS_PC});
      drainVerdicts();

      // overflow
      applyReset();
      writeReg(wbAdrT'(REG_ADR_BASE + 0), wbDataT'(PASS_PC));
      writeReg(wbAdrT'(REG_ADR_BASE + 1), wbDataT'(FAIL_PC));
      writeReg(wbAdrT'(REG_ADR_BASE + 2), wbDataT'(FINISH_PC));
      writeReg(wbAdrT'(REG_ADR_BASE + 4), wbDataT'(FAIL2_PC));
      applyRows(10, 16, FIFO_DEPTH + 1);
      readExpect("REG_STATUS overflow", REG_STATUS, 32'h8, 32'h8);
      drainVerdicts();

      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* project.f */
verilog/testMonPkg.sv
verilog/traceMatcher.sv
verilog/verdictFifo.sv
verilog/statusRegs.sv
verilog/testMonTop.sv
test/testMonTb.sv

/* Bender.yml */
package:
  name: testMon

sources:
  - verilog/testMonPkg.sv
  - verilog/traceMatcher.sv
  - verilog/verdictFifo.sv
  - verilog/statusRegs.sv
  - verilog/testMonTop.sv
  - target: test
    files:
      - test/testMonTb.sv
